// ==== filelist.f ====
source/core_pkg.sv
source/bpred_pkg.sv
source/bpred_res_if.sv
source/gshare.sv
source/btb.sv
source/fetch_pc_gen.sv
source/bpred_top.sv
testbench/bpred_checker.sv
testbench/bpred_monitor.sv
testbench/tb_bpred.sv

// ==== source/bpred_pkg.sv ====
// Branch prediction types and sizes: resolution struct, counter enum, history, BTB geometry
`default_nettype none

package bpred_pkg;

    import core_pkg::*;

    // ------------------------------------------------------------
    // Direction predictor sizing
    // ------------------------------------------------------------

    // Global history length, also the PHT index width
    localparam int HLEN = 4;
    localparam int PHT_ROWS = 1 << HLEN;

    // 2-bit saturating counter, upper bit gives the direction
    typedef enum logic [1:0] {
        SNT = 2'b00,
        WNT = 2'b01,
        WT  = 2'b10,
        ST  = 2'b11
    } c2b_t;

    // ------------------------------------------------------------
    // Branch target buffer geometry
    // ------------------------------------------------------------
    localparam int BTB_BITS = 4;
    localparam int BTB_ENTRIES = 1 << BTB_BITS;
    // Everything above the index is kept as tag
    localparam int BTB_TAG_LEN = XLEN - OFFSET - BTB_BITS;

    // One resolved branch coming back from execute
    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] target;
        logic            taken;
        logic            mispredict;
    } resolution_t;

endpackage

`default_nettype wire

// ==== source/bpred_res_if.sv ====
// Branch resolution interface with sink and redirect modports
`default_nettype none

interface bpred_res_if
    import bpred_pkg::*;
();

    // Single-cycle strobe, no handshake
    logic        valid;
    // Resolved branch payload, meaningful only with valid
    resolution_t res;
    // Pipeline flush request
    logic        flush;

    // ------------------------------------------------------------
    // Consumers
    // ------------------------------------------------------------

    // Table owners: gshare and BTB
    modport sink (
        input valid,
        input res,
        input flush
    );

    // PC generator, arms redirects on mispredicts
    modport redirect (
        input valid,
        input res,
        input flush
    );

endinterface

`default_nettype wire

// ==== source/bpred_top.sv ====
// Branch prediction top level: resolution interface, gshare, BTB and fetch PC generator
`default_nettype none

module bpred_top
    import core_pkg::*;
(
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            flush_i,
    // Branch resolution from the back end
    input  logic            res_valid_i,
    input  logic [XLEN-1:0] res_pc_i,
    input  logic [XLEN-1:0] res_target_i,
    input  logic            res_taken_i,
    input  logic            res_mispredict_i,
    // Fetch request towards instruction memory
    input  logic            pc_ack_i,
    output logic            pc_req_o,
    output logic [XLEN-1:0] pc_o,
    output logic            pred_taken_o,
    output logic [XLEN-1:0] pred_target_o
);

    // Lookup path between PC generator and tables
    logic [XLEN-1:0] lookup_pc;
    logic            dir_taken;
    logic            btb_hit;
    logic [XLEN-1:0] btb_target;

    // ------------------------------------------------------------
    // Resolution bundle
    // ------------------------------------------------------------
    bpred_res_if res_if ();

    assign res_if.valid = res_valid_i;
    assign res_if.flush = flush_i;
    assign res_if.res   = '{
        pc:         res_pc_i,
        target:     res_target_i,
        taken:      res_taken_i,
        mispredict: res_mispredict_i
    };

    // ------------------------------------------------------------
    // Blocks
    // ------------------------------------------------------------

    // Direction
    gshare gshare_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .res         (res_if.sink),
        .lookup_pc_i (lookup_pc),
        .taken_o     (dir_taken)
    );

    // Target
    btb btb_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .res         (res_if.sink),
        .lookup_pc_i (lookup_pc),
        .hit_o       (btb_hit),
        .target_o    (btb_target)
    );

    // PC stepping and handshake
    fetch_pc_gen fetch_pc_gen_i (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .res           (res_if.redirect),
        .dir_taken_i   (dir_taken),
        .btb_hit_i     (btb_hit),
        .btb_target_i  (btb_target),
        .lookup_pc_o   (lookup_pc),
        .pc_o          (pc_o),
        .pred_target_o (pred_target_o),
        .pred_taken_o  (pred_taken_o),
        .pc_req_o      (pc_req_o),
        .pc_ack_i      (pc_ack_i)
    );

endmodule

`default_nettype wire

// ==== source/btb.sv ====
// Direct-mapped branch target buffer with tag compare and valid bits
`default_nettype none

module btb
    import core_pkg::*;
    import bpred_pkg::*;
(
    input  logic            clk_i,
    input  logic            rst_n_i,
    bpred_res_if.sink       res,
    input  logic [XLEN-1:0] lookup_pc_i,
    output logic            hit_o,
    output logic [XLEN-1:0] target_o
);

    // ------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------

    // One valid bit per entry
    logic [BTB_ENTRIES-1:0] valid_q;
    // Tag and target arrays
    logic [BTB_TAG_LEN-1:0] tag_q [BTB_ENTRIES];
    logic [XLEN-1:0]        target_q [BTB_ENTRIES];

    // Lookup side fields
    logic [BTB_BITS-1:0]    idx_r;
    logic [BTB_TAG_LEN-1:0] tag_r;

    // Update side fields
    logic [BTB_BITS-1:0]    idx_w;
    logic [BTB_TAG_LEN-1:0] tag_w;
    logic                   upd_match;

    // ------------------------------------------------------------
    // Address split
    // ------------------------------------------------------------

    // Index sits just above the instruction offset
    assign idx_r = lookup_pc_i[BTB_BITS+OFFSET-1:OFFSET];
    assign tag_r = lookup_pc_i[XLEN-1:BTB_BITS+OFFSET];

    assign idx_w = res.res.pc[BTB_BITS+OFFSET-1:OFFSET];
    assign tag_w = res.res.pc[XLEN-1:BTB_BITS+OFFSET];

    // Resolved branch currently owns its entry
    assign upd_match = valid_q[idx_w] && (tag_q[idx_w] == tag_w);

    // ------------------------------------------------------------
    // Lookup
    // ------------------------------------------------------------

    // Pure combinational read of the current contents
    assign hit_o    = valid_q[idx_r] && (tag_q[idx_r] == tag_r);
    assign target_o = target_q[idx_r];

    // ------------------------------------------------------------
    // Valid bits
    // ------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (res.valid) begin
            if (res.res.taken) begin
                // Taken branch allocates or refreshes its slot
                valid_q[idx_w] <= 1'b1;
            end else if (upd_match) begin
                // Not taken drops the entry only if it is ours
                valid_q[idx_w] <= 1'b0;
            end
        end
    end

    // ------------------------------------------------------------
    // Tag and target payload
    // ------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (res.valid && res.res.taken) begin
            tag_q[idx_w]    <= tag_w;
            target_q[idx_w] <= res.res.target;
        end
    end

    // Flush has no effect on the BTB contents

endmodule

`default_nettype wire

// ==== source/core_pkg.sv ====
// Core-wide constants: address width, instruction offset, boot PC
`default_nettype none

package core_pkg;

    // Address and data width of the core
    localparam int XLEN = 64;

    // PC bits below the instruction index
    // Instructions are always 4 bytes here
    localparam int OFFSET = 2;

    // Byte distance between two sequential instructions
    localparam logic [XLEN-1:0] INSN_BYTES = XLEN'(1) << OFFSET;

    // First fetch address after reset
    localparam logic [XLEN-1:0] BOOT_PC = 64'h0000_0000_0000_1000;

endpackage

`default_nettype wire

// ==== source/fetch_pc_gen.sv ====
// Fetch PC generator: PC register, prediction capture, redirects, four-phase request
`default_nettype none

module fetch_pc_gen
    import core_pkg::*;
(
    input  logic            clk_i,
    input  logic            rst_n_i,
    bpred_res_if.redirect   res,
    input  logic            dir_taken_i,
    input  logic            btb_hit_i,
    input  logic [XLEN-1:0] btb_target_i,
    output logic [XLEN-1:0] lookup_pc_o,
    output logic [XLEN-1:0] pc_o,
    output logic [XLEN-1:0] pred_target_o,
    output logic            pred_taken_o,
    output logic            pc_req_o,
    input  logic            pc_ack_i
);

    // Current fetch PC
    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] pc_next;

    // Four-phase request state
    logic req_q;
    logic req_rise;
    logic req_fall;

    // Prediction frozen for the current request
    logic            pred_taken_q;
    logic [XLEN-1:0] pred_target_q;

    // Pending redirect from a mispredicted branch
    logic            redir_valid_q;
    logic [XLEN-1:0] redir_pc_q;
    logic            mispredict;

    // ------------------------------------------------------------
    // Handshake
    // ------------------------------------------------------------

    // Rise only once the previous ack has been dropped
    assign req_rise = !req_q && !pc_ack_i;
    // Drop one edge after ack is seen
    assign req_fall = req_q && pc_ack_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            req_q <= 1'b0;
        end else if (req_rise) begin
            req_q <= 1'b1;
        end else if (req_fall) begin
            req_q <= 1'b0;
        end
    end

    // ------------------------------------------------------------
    // Next PC selection
    // ------------------------------------------------------------
    assign mispredict = res.valid && res.res.mispredict;

    // Redirect beats prediction, prediction beats sequential
    assign pc_next = redir_valid_q ? redir_pc_q :
                     pred_taken_q  ? pred_target_q :
                     pc_q + INSN_BYTES;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q <= BOOT_PC;
        end else if (req_fall) begin
            pc_q <= pc_next;
        end
    end

    // ------------------------------------------------------------
    // Prediction capture
    // ------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pred_taken_q <= 1'b0;
        end else if (req_rise) begin
            // Needs both a taken direction and a known target
            pred_taken_q <= dir_taken_i && btb_hit_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_rise) begin
            pred_target_q <= btb_target_i;
        end
    end

    // ------------------------------------------------------------
    // Pending redirect
    // ------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            redir_valid_q <= 1'b0;
        end else if (mispredict) begin
            // Newest mispredict replaces any unapplied one
            redir_valid_q <= 1'b1;
        end else if (res.flush || req_fall) begin
            redir_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (mispredict) begin
            redir_pc_q <= res.res.taken ? res.res.target : res.res.pc + INSN_BYTES;
        end
    end

    // Outputs straight from registers
    assign lookup_pc_o   = pc_q;
    assign pc_o          = pc_q;
    assign pred_taken_o  = pred_taken_q;
    assign pred_target_o = pred_target_q;
    assign pc_req_o      = req_q;

endmodule

`default_nettype wire

// ==== source/gshare.sv ====
// gshare direction predictor: global history XOR PC indexing a 2-bit counter table
`default_nettype none

module gshare
    import core_pkg::*;
    import bpred_pkg::*;
(
    input  logic            clk_i,
    input  logic            rst_n_i,
    bpred_res_if.sink       res,
    input  logic [XLEN-1:0] lookup_pc_i,
    output logic            taken_o
);

    // Global branch history with the newest outcome in bit 0
    logic [HLEN-1:0] history_q;

    // Pattern history table
    c2b_t pht_q [PHT_ROWS];

    // Read and write indexes
    logic [HLEN-1:0] index_r;
    logic [HLEN-1:0] index_w;

    // ------------------------------------------------------------
    // Counter step with saturation at both ends
    // ------------------------------------------------------------
    function automatic c2b_t c2b_step(input c2b_t cnt, input logic taken);
        c2b_t nxt;
        nxt = cnt;
        case (cnt)
            SNT: nxt = taken ? WNT : SNT;
            WNT: nxt = taken ? WT  : SNT;
            WT:  nxt = taken ? ST  : WNT;
            ST:  nxt = taken ? ST  : WT;
        endcase
        return nxt;
    endfunction

    // ------------------------------------------------------------
    // Index hashing
    // ------------------------------------------------------------

    // Fetch side uses the current PC
    assign index_r = history_q ^ lookup_pc_i[HLEN+OFFSET-1:OFFSET];
    // Update side uses the resolved branch PC
    // History is the value before this resolution shifts in
    assign index_w = history_q ^ res.res.pc[HLEN+OFFSET-1:OFFSET];

    // ------------------------------------------------------------
    // History shift register
    // ------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            history_q <= '0;
        end else if (res.flush) begin
            // Flush wins over a resolution in the same cycle
            history_q <= '0;
        end else if (res.valid) begin
            history_q <= {history_q[HLEN-2:0], res.res.taken};
        end
    end

    // ------------------------------------------------------------
    // Pattern history table
    // ------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < PHT_ROWS; i++) begin
                pht_q[i] <= SNT;
            end
        end else if (res.flush) begin
            // Back to the reset state of all strongly not taken
            for (int i = 0; i < PHT_ROWS; i++) begin
                pht_q[i] <= SNT;
            end
        end else if (res.valid) begin
            pht_q[index_w] <= c2b_step(pht_q[index_w], res.res.taken);
        end
    end

    // Taken for both weak and strong taken states
    // Lookup sees the table before this cycle's update
    assign taken_o = (pht_q[index_r] == WT) || (pht_q[index_r] == ST);

endmodule

`default_nettype wire

// ==== testbench/bpred_checker.sv ====
// Bound concurrent assertions on the fetch handshake and reset behavior
`default_nettype none

module bpred_checker
    import core_pkg::*;
(
    input wire logic            clk_i,
    input wire logic            rst_n_i,
    input wire logic            pc_ack_i,
    input wire logic            pc_req_o,
    input wire logic [XLEN-1:0] pc_o,
    input wire logic            pred_taken_o,
    input wire logic [XLEN-1:0] pred_target_o
);

    timeunit 1ns;
    timeprecision 1ps;

    // Failed assertions, read by the testbench top
    int fail_count = 0;

    // No request while in reset
    req_low_in_reset: assert property (@(posedge clk_i) !rst_n_i |-> !pc_req_o)
        else begin
            $error("pc_req_o high during reset");
            fail_count++;
        end

    // Request payload holds until acknowledged
    req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (pc_req_o && !pc_ack_i) |=> $stable({pc_o, pred_taken_o, pred_target_o}))
        else begin
            $error("request outputs changed before ack");
            fail_count++;
        end

    // Ack seen means request drops on the next edge
    req_drop: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (pc_req_o && pc_ack_i) |=> !pc_req_o)
        else begin
            $error("pc_req_o did not fall after ack");
            fail_count++;
        end

    // Four-phase return to zero before the next request
    req_wait_ack_low: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (!pc_req_o && pc_ack_i) |=> !pc_req_o)
        else begin
            $error("pc_req_o rose while ack high");
            fail_count++;
        end

endmodule

`default_nettype wire

// ==== testbench/bpred_monitor.sv ====
// Reference model of gshare, BTB and fetch PC with per-request comparison and reporting
`default_nettype none

module bpred_monitor
    import core_pkg::*;
    import bpred_pkg::*;
(
    input  wire logic            clk_i,
    input  wire logic            rst_n_i,
    input  wire logic            flush_i,
    input  wire logic            res_valid_i,
    input  wire logic [XLEN-1:0] res_pc_i,
    input  wire logic [XLEN-1:0] res_target_i,
    input  wire logic            res_taken_i,
    input  wire logic            res_mispredict_i,
    input  wire logic            pc_ack_i,
    input  wire logic            pc_req_i,
    input  wire logic [XLEN-1:0] pc_i,
    input  wire logic            pred_taken_i,
    input  wire logic [XLEN-1:0] pred_target_i,
    input  wire logic [191:0]    test_name_i,
    input  wire logic            done_i,
    output int                   error_count_o,
    output int                   check_count_o
);

    timeunit 1ns;
    timeprecision 1ps;

    // Model state
    logic [HLEN-1:0]        m_hist;
    c2b_t                   m_pht [PHT_ROWS];
    logic                   m_bvalid [BTB_ENTRIES];
    logic [BTB_TAG_LEN-1:0] m_btag [BTB_ENTRIES];
    logic [XLEN-1:0]        m_btgt [BTB_ENTRIES];
    logic [XLEN-1:0]        m_pc;
    logic                   m_req;
    logic                   m_ptaken;
    logic [XLEN-1:0]        m_ptgt;
    logic                   m_redir;
    logic [XLEN-1:0]        m_rpc;
    logic                   check_due;

    // Per-test bookkeeping
    string cur_test = "";
    int    test_checks = 0;
    int    test_errors = 0;
    int    pass_count = 0;
    int    fail_count = 0;

    initial begin
        error_count_o = 0;
        check_count_o = 0;
    end

    // Packed name from the pattern file, leading zero bytes dropped
    function automatic string name_str(input logic [191:0] v);
        string s;
        s = "";
        for (int i = 23; i >= 0; i--) begin
            if (v[i*8 +: 8] != 8'h00) s = $sformatf("%s%c", s, v[i*8 +: 8]);
        end
        return s;
    endfunction

    task automatic report_test();
        if (cur_test != "") begin
            if (test_errors == 0) begin
                $display("PASS %s (%0d requests)", cur_test, test_checks);
                pass_count++;
            end else begin
                $display("FAIL %s (%0d of %0d requests wrong)", cur_test, test_errors,
                         test_checks);
                fail_count++;
            end
        end
        test_checks = 0;
        test_errors = 0;
    endtask

    // ------------------------------------------------------------
    // Model update, one step per rising clock edge
    // ------------------------------------------------------------
    always @(posedge clk_i or negedge rst_n_i) begin
        logic                rise;
        logic                fall;
        logic [HLEN-1:0]     ridx;
        logic [HLEN-1:0]     widx;
        logic [BTB_BITS-1:0] bidx;
        logic [BTB_BITS-1:0] wbidx;
        logic                hit;
        if (!rst_n_i) begin
            m_hist = '0;
            for (int i = 0; i < PHT_ROWS; i++) m_pht[i] = SNT;
            for (int i = 0; i < BTB_ENTRIES; i++) m_bvalid[i] = 1'b0;
            m_pc = BOOT_PC;
            m_req = 1'b0;
            m_ptaken = 1'b0;
            m_redir = 1'b0;
            check_due = 1'b0;
        end else begin
            rise = !m_req && !pc_ack_i;
            fall = m_req && pc_ack_i;
            // Lookup on the contents before this edge
            ridx = m_hist ^ m_pc[HLEN+OFFSET-1:OFFSET];
            bidx = m_pc[BTB_BITS+OFFSET-1:OFFSET];
            hit = m_bvalid[bidx] && (m_btag[bidx] == m_pc[XLEN-1:BTB_BITS+OFFSET]);
            if (fall) begin
                if (m_redir) m_pc = m_rpc;
                else if (m_ptaken) m_pc = m_ptgt;
                else m_pc = m_pc + 4;
            end
            if (rise) begin
                m_ptaken = m_pht[ridx][1] && hit;
                m_ptgt = m_btgt[bidx];
                check_due = 1'b1;
            end
            // Pending redirect, newest mispredict wins
            if (res_valid_i && res_mispredict_i) begin
                m_redir = 1'b1;
                m_rpc = res_taken_i ? res_target_i : res_pc_i + 4;
            end else if (flush_i || fall) begin
                m_redir = 1'b0;
            end
            // gshare tables
            widx = m_hist ^ res_pc_i[HLEN+OFFSET-1:OFFSET];
            if (flush_i) begin
                m_hist = '0;
                for (int i = 0; i < PHT_ROWS; i++) m_pht[i] = SNT;
            end else if (res_valid_i) begin
                if (res_taken_i && m_pht[widx] != ST) m_pht[widx] = c2b_t'(m_pht[widx] + 1);
                if (!res_taken_i && m_pht[widx] != SNT) m_pht[widx] = c2b_t'(m_pht[widx] - 1);
                m_hist = {m_hist[HLEN-2:0], res_taken_i};
            end
            // BTB ignores flush
            wbidx = res_pc_i[BTB_BITS+OFFSET-1:OFFSET];
            if (res_valid_i && res_taken_i) begin
                m_bvalid[wbidx] = 1'b1;
                m_btag[wbidx] = res_pc_i[XLEN-1:BTB_BITS+OFFSET];
                m_btgt[wbidx] = res_target_i;
            end else if (res_valid_i && m_bvalid[wbidx] &&
                         m_btag[wbidx] == res_pc_i[XLEN-1:BTB_BITS+OFFSET]) begin
                m_bvalid[wbidx] = 1'b0;
            end
            if (rise) m_req = 1'b1;
            else if (fall) m_req = 1'b0;
        end
    end

    // ------------------------------------------------------------
    // Comparison on the falling edge, outputs settled
    // ------------------------------------------------------------
    always @(negedge clk_i) begin
        string nm;
        logic  bad;
        if (rst_n_i) begin
            if (pc_req_i !== m_req) begin
                $display("Request line out of step with the handshake at %0t", $time);
                error_count_o++;
            end
            if (check_due) begin
                check_due = 1'b0;
                nm = name_str(test_name_i);
                if (nm != cur_test) begin
                    report_test();
                    cur_test = nm;
                end
                bad = 1'b0;
                if (pc_i !== m_pc) begin
                    $display("ERROR %s pc expected %h actual %h", nm, m_pc, pc_i);
                    bad = 1'b1;
                end
                if (pred_taken_i !== m_ptaken) begin
                    $display("ERROR %s taken expected %b actual %b", nm, m_ptaken,
                             pred_taken_i);
                    bad = 1'b1;
                end
                if (m_ptaken && pred_target_i !== m_ptgt) begin
                    $display("ERROR %s target expected %h actual %h", nm, m_ptgt,
                             pred_target_i);
                    bad = 1'b1;
                end
                test_checks++;
                check_count_o++;
                if (bad) begin
                    test_errors++;
                    error_count_o++;
                end
            end
        end
    end

    // Last test and the totals
    always @(posedge done_i) begin
        report_test();
        $display("Tests: %0d passed, %0d failed, %0d requests, %0d errors",
                 pass_count, fail_count, check_count_o, error_count_o);
    end

endmodule

`default_nettype wire

// ==== testbench/bpred_patterns.txt ====
# Columns: res_valid res_pc res_target res_taken res_mispredict flush test_name
# Each line waits for one fetch request, then drives its resolution while req is low
0 0 0 0 0 0 boot_seq
0 0 0 0 0 0 boot_seq
0 0 0 0 0 0 boot_seq
0 0 0 0 0 0 boot_seq
1 1040 1040 1 0 0 train_taken
1 1040 1040 1 0 0 train_taken
1 1040 1040 1 0 0 train_taken
1 1040 1040 1 0 0 train_taken
1 1040 1040 1 0 0 train_taken
1 1040 1040 1 1 0 train_taken
0 0 0 0 0 0 predict_taken
0 0 0 0 0 0 predict_taken
0 0 0 0 0 0 predict_taken
1 1040 1044 0 0 0 untrain
1 1040 1044 0 0 0 untrain
0 0 0 0 0 0 untrain
1 2004 3000 1 1 0 redirect
1 3010 3100 0 1 0 redirect
0 0 0 0 0 0 redirect
0 0 0 0 0 0 redirect
1 1040 1040 1 0 0 flush_keep_btb
1 1040 1040 1 0 0 flush_keep_btb
1 1040 1040 1 0 0 flush_keep_btb
1 1040 1040 1 0 0 flush_keep_btb
1 1040 1040 1 1 0 flush_keep_btb
0 0 0 0 0 1 flush_keep_btb
1 1040 1040 1 1 0 retrain
1 1040 1040 1 1 0 retrain
1 1040 1040 1 1 0 retrain
1 1040 1040 1 1 0 retrain
0 0 0 0 0 0 retrain
0 0 0 0 0 0 retrain

// ==== testbench/tb_bpred.sv ====
// Testbench top: clock, reset, pattern reading, LFSR ack delays, stimulus and watchdog
`default_nettype none

module tb_bpred
    import core_pkg::*;
;

    timeunit 1ns;
    timeprecision 1ps;

    logic            clk_i;
    logic            rst_n_i;
    logic            flush_i;
    logic            res_valid_i;
    logic [XLEN-1:0] res_pc_i;
    logic [XLEN-1:0] res_target_i;
    logic            res_taken_i;
    logic            res_mispredict_i;
    logic            pc_ack_i;
    logic            pc_req_o;
    logic [XLEN-1:0] pc_o;
    logic            pred_taken_o;
    logic [XLEN-1:0] pred_target_o;

    // Stimulus table loaded from the pattern file
    logic            p_valid [64];
    logic [XLEN-1:0] p_pc [64];
    logic [XLEN-1:0] p_target [64];
    logic            p_taken [64];
    logic            p_mispredict [64];
    logic            p_flush [64];
    logic [191:0]    p_name [64];
    int              num_lines = 0;

    logic [191:0] test_name;
    logic         done;
    logic [31:0]  lfsr = 32'd85458;
    int           mon_errors;
    int           mon_checks;

    always #5 clk_i = ~clk_i;

    bpred_top dut_i (.*);

    bpred_monitor monitor_i (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .flush_i(flush_i),
        .res_valid_i(res_valid_i), .res_pc_i(res_pc_i), .res_target_i(res_target_i),
        .res_taken_i(res_taken_i), .res_mispredict_i(res_mispredict_i),
        .pc_ack_i(pc_ack_i), .pc_req_i(pc_req_o), .pc_i(pc_o),
        .pred_taken_i(pred_taken_o), .pred_target_i(pred_target_o),
        .test_name_i(test_name), .done_i(done),
        .error_count_o(mon_errors), .check_count_o(mon_checks)
    );

    bind bpred_top bpred_checker chk_i (.*);

    // Galois LFSR stepped once per random bit
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic load_patterns();
        int    fd;
        string line;
        int    n;
        fd = $fopen("testbench/bpred_patterns.txt", "r");
        if (fd == 0) begin
            $display("Could not open the pattern file");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%h %h %h %h %h %h %s", p_valid[num_lines],
                                p_pc[num_lines], p_target[num_lines], p_taken[num_lines],
                                p_mispredict[num_lines], p_flush[num_lines],
                                p_name[num_lines]);
                    if (n == 7) num_lines++;
                end
            end
            $fclose(fd);
        end
    endtask

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------
    initial begin
        int delay;
        clk_i = 1'b0;
        rst_n_i = 1'b0;
        flush_i = 1'b0;
        res_valid_i = 1'b0;
        res_pc_i = '0;
        res_target_i = '0;
        res_taken_i = 1'b0;
        res_mispredict_i = 1'b0;
        pc_ack_i = 1'b0;
        test_name = '0;
        done = 1'b0;
        load_patterns();
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;
        for (int i = 0; i < num_lines; i++) begin
            test_name = p_name[i];
            while (!pc_req_o) @(negedge clk_i);
            // Ack delay of 0 to 3 cycles from two LFSR bits
            delay = 0;
            for (int b = 0; b < 2; b++) begin
                delay = (delay << 1) | lfsr[0];
                lfsr = lfsr_next(lfsr);
            end
            repeat (delay) @(negedge clk_i);
            pc_ack_i = 1'b1;
            @(negedge clk_i);
            while (pc_req_o) @(negedge clk_i);
            // Resolution strobe while the request is low
            res_valid_i = p_valid[i];
            res_pc_i = p_pc[i];
            res_target_i = p_target[i];
            res_taken_i = p_taken[i];
            res_mispredict_i = p_mispredict[i];
            flush_i = p_flush[i];
            @(negedge clk_i);
            res_valid_i = 1'b0;
            flush_i = 1'b0;
            pc_ack_i = 1'b0;
        end
        repeat (2) @(negedge clk_i);
        done = 1'b1;
        @(negedge clk_i);
        if (mon_errors == 0 && dut_i.chk_i.fail_count == 0 && mon_checks > 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // Watchdog scaled to the pattern count
    initial begin
        wait (num_lines > 0);
        repeat (num_lines * 12 + 50) @(posedge clk_i);
        $display("Timed out waiting for the fetch handshake");
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire
